//--- hdl/cfo_derotator.sv
`timescale 1ns/10ps
`default_nettype none

module cfo_derotator (
    input  wire                                             clk_i,
    input  wire                                             reset_ni,
    input  wire logic signed [rx_frontend_pkg::IQ_W-1:0]    sample_i_i,
    input  wire logic signed [rx_frontend_pkg::IQ_W-1:0]    sample_q_i,
    input  wire                                             sample_valid_i,
    input  wire logic signed [rx_frontend_pkg::PHASE_W-1:0] cfo_inc_i,
    input  wire                                             cfo_valid_i,
    input  wire                                             cfo_manual_i,
    output logic                                            push_o,
    output rx_frontend_pkg::rx_sample_t                     push_data_o
);

    localparam int IQ_W    = rx_frontend_pkg::IQ_W;
    localparam int OUT_W   = rx_frontend_pkg::OUT_W;
    localparam int PHASE_W = rx_frontend_pkg::PHASE_W;
    localparam int ID_W    = rx_frontend_pkg::ID_W;
    localparam int TRIG_W  = rx_frontend_pkg::TRIG_W;
    localparam int PROD_W  = IQ_W + TRIG_W + 1;

    localparam logic signed [TRIG_W-1:0] T_ONE  = rx_frontend_pkg::COS_SIN_ONE;
    localparam logic signed [TRIG_W-1:0] T_DIAG = rx_frontend_pkg::COS_SIN_DIAG;

    logic signed [PHASE_W-1:0] freq_word;
    logic [PHASE_W-1:0]        phase;
    logic [ID_W-1:0]           sample_cnt;

    logic signed [TRIG_W-1:0]  cos_lut;
    logic signed [TRIG_W-1:0]  sin_lut;

    logic                      s1_valid;
    logic signed [IQ_W-1:0]    s1_i;
    logic signed [IQ_W-1:0]    s1_q;
    logic [ID_W-1:0]           s1_id;
    logic signed [TRIG_W-1:0]  s1_cos;
    logic signed [TRIG_W-1:0]  s1_sin;

    logic signed [PROD_W-1:0]  sum_i;
    logic signed [PROD_W-1:0]  sum_q;
    logic signed [PROD_W-1:0]  shift_i;
    logic signed [PROD_W-1:0]  shift_q;

    // ------------------------------------------------------------
    // sample id, frequency word and phase
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            freq_word  <= '0;
            phase      <= '0;
            sample_cnt <= '0;
        end else begin
            if (sample_valid_i) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            if (cfo_manual_i) begin
                freq_word <= '0;
                phase     <= '0;
            end else begin
                // offset updates are relative to the word held so far
                if (cfo_valid_i) begin
                    freq_word <= freq_word - cfo_inc_i;
                end
                if (sample_valid_i) begin
                    phase <= phase + freq_word;
                end
            end
        end
    end

    // eight-point table, one entry per 45 degree octant
    always_comb begin
        case (phase[PHASE_W-1 -: 3])
            3'd0: begin cos_lut = T_ONE;   sin_lut = '0;      end
            3'd1: begin cos_lut = T_DIAG;  sin_lut = T_DIAG;  end
            3'd2: begin cos_lut = '0;      sin_lut = T_ONE;   end
            3'd3: begin cos_lut = -T_DIAG; sin_lut = T_DIAG;  end
            3'd4: begin cos_lut = -T_ONE;  sin_lut = '0;      end
            3'd5: begin cos_lut = -T_DIAG; sin_lut = -T_DIAG; end
            3'd6: begin cos_lut = '0;      sin_lut = -T_ONE;  end
            default: begin cos_lut = T_DIAG; sin_lut = -T_DIAG; end
        endcase
    end

    // ------------------------------------------------------------
    // stage 1: table lookup
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= sample_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            s1_i   <= sample_i_i;
            s1_q   <= sample_q_i;
            s1_id  <= sample_cnt;
            s1_cos <= cos_lut;
            s1_sin <= sin_lut;
        end
    end

    // ------------------------------------------------------------
    // stage 2: complex multiply by the conjugate
    // ------------------------------------------------------------
    always_comb begin
        sum_i   = s1_i * s1_cos + s1_q * s1_sin;
        sum_q   = s1_q * s1_cos - s1_i * s1_sin;
        // floor rounding
        shift_i = sum_i >>> rx_frontend_pkg::TRIG_SHIFT;
        shift_q = sum_q >>> rx_frontend_pkg::TRIG_SHIFT;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            push_o <= 1'b0;
        end else begin
            push_o <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid) begin
            push_data_o.sample_id <= s1_id;
            push_data_o.i         <= shift_i[OUT_W-1:0];
            push_data_o.q         <= shift_q[OUT_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/rx_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module rx_frontend #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                                             clk_i,
    input  wire                                             reset_ni,
    input  wire logic signed [rx_frontend_pkg::IQ_W-1:0]    sample_i_i,
    input  wire logic signed [rx_frontend_pkg::IQ_W-1:0]    sample_q_i,
    input  wire                                             sample_valid_i,
    input  wire logic signed [rx_frontend_pkg::PHASE_W-1:0] cfo_inc_i,
    input  wire                                             cfo_valid_i,
    input  wire                                             cfo_manual_i,
    input  wire                                             wb_cyc_i,
    input  wire                                             wb_stb_i,
    input  wire                                             wb_we_i,
    input  wire [rx_frontend_pkg::WB_ADDR_W-1:0]            wb_adr_i,
    input  wire [rx_frontend_pkg::WB_DATA_W-1:0]            wb_dat_i,
    output wire [rx_frontend_pkg::WB_DATA_W-1:0]            wb_dat_o,
    output wire                                             wb_ack_o
);

    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    wire                              push;
    rx_frontend_pkg::rx_sample_t      push_data;
    rx_frontend_pkg::rx_sample_t      head;
    wire                              empty;
    wire                              full;
    wire [LVL_W-1:0]                  level;
    wire                              dropped;
    wire                              pop;

    // ------------------------------------------------------------
    // producer, buffer, host side
    // ------------------------------------------------------------
    cfo_derotator derotator_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i_i     (sample_i_i),
        .sample_q_i     (sample_q_i),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_manual_i   (cfo_manual_i),
        .push_o         (push),
        .push_data_o    (push_data)
    );

    sample_fifo #(
        .payload_t (rx_frontend_pkg::rx_sample_t),
        .DEPTH     (FIFO_DEPTH)
    ) fifo_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .full_o      (full),
        .level_o     (level),
        .dropped_o   (dropped)
    );

    wb_sample_reader #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) reader_i (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .head_i    (head),
        .empty_i   (empty),
        .full_i    (full),
        .level_i   (level),
        .dropped_i (dropped),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .pop_o     (pop)
    );

endmodule

`default_nettype wire

//--- hdl/rx_frontend_pkg.sv
`default_nettype none

package rx_frontend_pkg;

    // ------------------------------------------------------------
    // sample path widths
    // ------------------------------------------------------------
    localparam int IQ_W    = 12;
    localparam int OUT_W   = IQ_W + 1;
    localparam int PHASE_W = 8;
    localparam int ID_W    = 16;

    // cos/sin table, Q1.8
    localparam int TRIG_W     = 10;
    localparam int TRIG_SHIFT = 8;
    localparam logic signed [TRIG_W-1:0] COS_SIN_ONE  = 256;
    // 1/sqrt(2)
    localparam logic signed [TRIG_W-1:0] COS_SIN_DIAG = 181;

    // ------------------------------------------------------------
    // wishbone register map
    // ------------------------------------------------------------
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    localparam logic [WB_ADDR_W-1:0] ADDR_STATUS  = 4'd0;
    localparam logic [WB_ADDR_W-1:0] ADDR_POP     = 4'd1;
    localparam logic [WB_ADDR_W-1:0] ADDR_HEAD_ID = 4'd2;

    // derotated sample as stored in the buffer
    typedef struct packed {
        logic [ID_W-1:0]         sample_id;
        logic signed [OUT_W-1:0] i;
        logic signed [OUT_W-1:0] q;
    } rx_sample_t;

endpackage

`default_nettype wire

//--- hdl/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 16,
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int LVL_W = $clog2(DEPTH + 1)
) (
    input  wire                 clk_i,
    input  wire                 reset_ni,
    input  wire                 push_i,
    input  wire payload_t       push_data_i,
    input  wire                 pop_i,
    output payload_t            head_o,
    output logic                empty_o,
    output logic                full_o,
    output logic [LVL_W-1:0]    level_o,
    output logic                dropped_o
);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [LVL_W-1:0] FULL_LVL = LVL_W'(DEPTH);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [LVL_W-1:0]  level;
    logic              push_ok;
    logic              pop_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    // full drops the push, empty ignores the pop
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            dropped_o <= 1'b0;
        end else begin
            dropped_o <= push_i && full_o;
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_ok, pop_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign head_o  = mem[rd_ptr];
    assign empty_o = (level == '0);
    assign full_o  = (level == FULL_LVL);
    assign level_o = level;

endmodule

`default_nettype wire

//--- hdl/wb_sample_reader.sv
`timescale 1ns/10ps
`default_nettype none

module wb_sample_reader #(
    parameter int FIFO_DEPTH = 16,
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1)
) (
    input  wire                                       clk_i,
    input  wire                                       reset_ni,
    input  wire                                       wb_cyc_i,
    input  wire                                       wb_stb_i,
    input  wire                                       wb_we_i,
    input  wire [rx_frontend_pkg::WB_ADDR_W-1:0]      wb_adr_i,
    input  wire [rx_frontend_pkg::WB_DATA_W-1:0]      wb_dat_i,
    input  wire rx_frontend_pkg::rx_sample_t          head_i,
    input  wire                                       empty_i,
    input  wire                                       full_i,
    input  wire [LVL_W-1:0]                           level_i,
    input  wire                                       dropped_i,
    output logic [rx_frontend_pkg::WB_DATA_W-1:0]     wb_dat_o,
    output logic                                      wb_ack_o,
    output logic                                      pop_o
);

    localparam int DATA_W = rx_frontend_pkg::WB_DATA_W;
    localparam int ID_W   = rx_frontend_pkg::ID_W;

    logic                     req;
    logic                     sel_status;
    logic                     sel_pop;
    logic                     sel_head;
    logic                     overflow;
    logic                     clear_ovf;
    logic signed [15:0]       i_ext;
    logic signed [15:0]       q_ext;
    logic [DATA_W-1:0]        status_word;
    logic [DATA_W-1:0]        pop_word;
    logic [DATA_W-1:0]        id_word;
    logic [DATA_W-1:0]        rd_data;

    // new request only, the held stb during ack is not a second one
    assign req        = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign sel_status = (wb_adr_i == rx_frontend_pkg::ADDR_STATUS);
    assign sel_pop    = (wb_adr_i == rx_frontend_pkg::ADDR_POP);
    assign sel_head   = (wb_adr_i == rx_frontend_pkg::ADDR_HEAD_ID);
    assign clear_ovf  = req && wb_we_i && sel_status;

    // ------------------------------------------------------------
    // read data
    // ------------------------------------------------------------
    always_comb begin
        i_ext = head_i.i;
        q_ext = head_i.q;

        status_word             = '0;
        status_word[0]          = empty_i;
        status_word[1]          = full_i;
        status_word[2]          = overflow;
        status_word[8 +: LVL_W] = level_i;

        // nothing to pop reads as zero
        pop_word = empty_i ? '0 : {q_ext, i_ext};

        id_word             = '0;
        id_word[ID_W-1:0]   = head_i.sample_id;

        if (sel_status) begin
            rd_data = status_word;
        end else if (sel_pop) begin
            rd_data = pop_word;
        end else if (sel_head) begin
            rd_data = id_word;
        end else begin
            rd_data = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_dat_o <= wb_we_i ? '0 : rd_data;
        end
    end

    // ------------------------------------------------------------
    // handshake, pop and sticky overflow
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wb_ack_o <= 1'b0;
            pop_o    <= 1'b0;
            overflow <= 1'b0;
        end else begin
            wb_ack_o <= req;
            // pop lands with ack, head held until then
            pop_o    <= req && !wb_we_i && sel_pop && !empty_i;
            if (clear_ovf) begin
                overflow <= 1'b0;
            end else if (dropped_i) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/rx_frontend_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module rx_frontend_assertions #(
    parameter int DEPTH = 16,
    parameter int LVL_W = $clog2(DEPTH + 1)
) (
    input wire             clk_i,
    input wire             reset_ni,
    input wire             push_i,
    input wire             pop_i,
    input wire             full_i,
    input wire             empty_i,
    input wire [LVL_W-1:0] level_i,
    input wire             ack_i
);

    int assert_errors = 0;

    level_bound: assert property (@(posedge clk_i) disable iff (!reset_ni)
        level_i <= DEPTH)
        else begin
            assert_errors++;
            $error("fifo level above depth");
        end

    // a push into a full buffer must not grow the level
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (push_i && full_i) |=> (level_i <= $past(level_i)))
        else begin
            assert_errors++;
            $error("push accepted while fifo full");
        end

    no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (pop_i && empty_i && !push_i) |=> (level_i == $past(level_i)))
        else begin
            assert_errors++;
            $error("fifo level changed on pop while empty");
        end

    single_cycle_ack: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ack_i |=> !ack_i)
        else begin
            assert_errors++;
            $error("wishbone ack high for two cycles");
        end

endmodule

bind rx_frontend rx_frontend_assertions #(
    .DEPTH (FIFO_DEPTH)
) fifo_checks (
    .clk_i    (clk_i),
    .reset_ni (reset_ni),
    .push_i   (push),
    .pop_i    (pop),
    .full_i   (full),
    .empty_i  (empty),
    .level_i  (level),
    .ack_i    (wb_ack_o)
);

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tests/tb_rx_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rx_frontend;

    localparam int IQ_W      = rx_frontend_pkg::IQ_W;
    localparam int PHASE_W   = rx_frontend_pkg::PHASE_W;
    localparam int ADDR_W    = rx_frontend_pkg::WB_ADDR_W;
    localparam int DATA_W    = rx_frontend_pkg::WB_DATA_W;
    localparam int DEPTH     = 16;
    localparam int N_MANUAL  = 12;
    localparam int N_ROTATE  = 16;
    localparam int N_FILL    = 24;
    localparam int N_MIXED   = 30;
    localparam int N_SAMPLES = N_MANUAL + N_ROTATE + N_FILL + N_MIXED;
    // head id and pop per sample read back, plus the status accesses and the empty pop
    localparam int N_BUS     = 2 * (N_MANUAL + N_ROTATE + DEPTH + N_MIXED) + 6;
    localparam int MAX_CYCLES = 4 * (N_SAMPLES + N_BUS) + 200;

    wire                       clk;
    logic                      reset_n;
    logic signed [IQ_W-1:0]    sample_i;
    logic signed [IQ_W-1:0]    sample_q;
    logic                      sample_valid;
    logic [PHASE_W-1:0]        cfo_inc;
    logic                      cfo_valid;
    logic                      cfo_manual;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [ADDR_W-1:0]         wb_adr;
    logic [DATA_W-1:0]         wb_dat_w;
    wire  [DATA_W-1:0]         wb_dat_r;
    wire                       wb_ack;

    // reference model state
    logic [PHASE_W-1:0]        model_word;
    logic [PHASE_W-1:0]        model_phase;
    logic [15:0]               model_id;
    logic                      model_ovf;
    logic [15:0]               exp_id_q[$];
    logic [DATA_W-1:0]         exp_word_q[$];
    logic [DATA_W-1:0]         popped_word;
    event                      pop_seen;
    event                      compare_done;
    int                        mismatch_count = 0;
    int                        bus_count = 0;
    int                        cycle_cnt = 0;
    integer                    seed;

    tb_clock_gen #(.PERIOD_NS(20)) clock_gen (.clk_o(clk));

    rx_frontend #(.FIFO_DEPTH(DEPTH)) uut (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i_i     (sample_i),
        .sample_q_i     (sample_q),
        .sample_valid_i (sample_valid),
        .cfo_inc_i      (cfo_inc),
        .cfo_valid_i    (cfo_valid),
        .cfo_manual_i   (cfo_manual),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack)
    );

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic integer cos_ref(input logic [2:0] k);
        case (k)
            3'd0: cos_ref = 256;
            3'd1: cos_ref = 181;
            3'd2: cos_ref = 0;
            3'd3: cos_ref = -181;
            3'd4: cos_ref = -256;
            3'd5: cos_ref = -181;
            3'd6: cos_ref = 0;
            default: cos_ref = 181;
        endcase
    endfunction

    // sine lags cosine by two octants
    function automatic integer sin_ref(input logic [2:0] k);
        logic [2:0] km;
        km = k - 3'd2;
        sin_ref = cos_ref(km);
    endfunction

    function automatic logic [DATA_W-1:0] derotate_ref(input logic signed [IQ_W-1:0] i,
                                                     input logic signed [IQ_W-1:0] q,
                                                     input logic [PHASE_W-1:0] phase);
        integer c;
        integer s;
        integer ri;
        integer rq;
        c  = cos_ref(phase[PHASE_W-1 -: 3]);
        s  = sin_ref(phase[PHASE_W-1 -: 3]);
        ri = (i * c + q * s) >>> 8;
        rq = (q * c - i * s) >>> 8;
        derotate_ref = {rq[15:0], ri[15:0]};
    endfunction

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            sample_valid <= 1'b0;
            cfo_valid    <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        reset_n <= 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        model_word  = '0;
        model_phase = '0;
        model_id    = '0;
        model_ovf   = 1'b0;
        exp_id_q.delete();
        exp_word_q.delete();
    endtask

    task automatic set_manual(input logic m);
        @(posedge clk);
        cfo_manual   <= m;
        sample_valid <= 1'b0;
        cfo_valid    <= 1'b0;
        if (m) begin
            model_word  = '0;
            model_phase = '0;
        end
    endtask

    task automatic drive_sample(input logic signed [IQ_W-1:0] i,
                                input logic signed [IQ_W-1:0] q,
                                input logic do_cfo,
                                input logic [PHASE_W-1:0] inc);
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_i     <= i;
        sample_q     <= q;
        cfo_valid    <= do_cfo;
        cfo_inc      <= inc;
        if (exp_word_q.size() < DEPTH) begin
            exp_word_q.push_back(derotate_ref(i, q, model_phase));
            exp_id_q.push_back(model_id);
        end else begin
            // dropped, but the id is used up
            model_ovf = 1'b1;
        end
        model_id = model_id + 1'b1;
        if (!cfo_manual) begin
            model_phase = model_phase + model_word;
            if (do_cfo) begin
                model_word = model_word - inc;
            end
        end
    endtask

    task automatic wb_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        @(posedge clk);
        sample_valid <= 1'b0;
        cfo_valid    <= 1'b0;
        wb_cyc       <= 1'b1;
        wb_stb       <= 1'b1;
        wb_we        <= we;
        wb_adr       <= addr;
        wb_dat_w     <= wdata;
        while (!acked && waited < 4) begin
            @(posedge clk);
            waited++;
            acked = wb_ack;
        end
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!acked) begin
            bus_count++;
            $display("error: no ack within 4 cycles for access to address %h", addr);
        end
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic check_status();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        exp       = '0;
        exp[0]    = (exp_word_q.size() == 0);
        exp[1]    = (exp_word_q.size() == DEPTH);
        exp[2]    = model_ovf;
        exp[15:8] = 8'(exp_word_q.size());
        wb_read(rx_frontend_pkg::ADDR_STATUS, got);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch wb_dat_o status: expected %h actual %h", exp, got);
        end
    endtask

    task automatic check_head_id();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        exp = {16'h0, exp_id_q[0]};
        wb_read(rx_frontend_pkg::ADDR_HEAD_ID, got);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch wb_dat_o head id: expected %h actual %h", exp, got);
        end
    endtask

    task automatic pop_read();
        wb_read(rx_frontend_pkg::ADDR_POP, popped_word);
        -> pop_seen;
        @(compare_done);
    endtask

    task automatic read_sample();
        check_head_id();
        pop_read();
    endtask

    initial begin : compare_pops
        logic [DATA_W-1:0] exp;
        logic [15:0]       exp_id;
        forever begin
            @(pop_seen);
            exp    = '0;
            exp_id = '0;
            if (exp_word_q.size() > 0) begin
                exp    = exp_word_q.pop_front();
                exp_id = exp_id_q.pop_front();
            end
            if (popped_word !== exp) begin
                mismatch_count++;
                $display("mismatch wb_dat_o pop of id %h: expected %h actual %h",
                         exp_id, exp, popped_word);
            end
            -> compare_done;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("error: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : run_tests
        logic [31:0] r;
        logic [31:0] r2;
        int          left;
        int          total;
        seed         = 32'h9d23_ab61;
        reset_n      = 1'b0;
        sample_i     = '0;
        sample_q     = '0;
        sample_valid = 1'b0;
        cfo_inc      = '0;
        cfo_valid    = 1'b0;
        cfo_manual   = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        apply_reset();

        // empty after reset
        idle(2);
        check_status();
        pop_read();

        // manual mode ignores offset updates
        set_manual(1'b1);
        repeat (N_MANUAL) begin
            r  = $random(seed);
            r2 = $random(seed);
            drive_sample(r[11:0], r[23:12], r2[0], r2[15:8]);
        end
        idle(4);
        repeat (N_MANUAL) read_sample();

        // derotation with relative offset updates
        set_manual(1'b0);
        repeat (N_ROTATE) begin
            r  = $random(seed);
            r2 = $random(seed);
            drive_sample(r[11:0], r[23:12], r2[1:0] != 2'b00, r2[15:8]);
        end
        idle(4);
        repeat (N_ROTATE) read_sample();

        // overflow, ids restart after reset
        apply_reset();
        repeat (N_FILL) begin
            r  = $random(seed);
            r2 = $random(seed);
            drive_sample(r[11:0], r[23:12], r2[0], r2[15:8]);
        end
        idle(5);
        check_status();
        repeat (DEPTH) read_sample();
        check_status();
        wb_write(rx_frontend_pkg::ADDR_STATUS, 32'h0);
        model_ovf = 1'b0;
        check_status();

        // random mix of input and reads, kept below full
        left = N_MIXED;
        while (left > 0 || exp_word_q.size() > 0) begin
            r  = $random(seed);
            r2 = $random(seed);
            if (left > 0 && (exp_word_q.size() == 0
                             || (exp_word_q.size() < DEPTH - 4 && r2[0]))) begin
                drive_sample(r[11:0], r[23:12], r2[3:1] == 3'b000, r2[15:8]);
                left--;
            end else begin
                idle(2);
                read_sample();
            end
        end

        idle(2);
        total = mismatch_count + bus_count + uut.fifo_checks.assert_errors;
        $display("errors: %0d mismatch, %0d bus, %0d assertion",
                 mismatch_count, bus_count, uut.fifo_checks.assert_errors);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/rx_frontend_pkg.sv
hdl/cfo_derotator.sv
hdl/sample_fifo.sv
hdl/wb_sample_reader.sv
hdl/rx_frontend.sv
tests/tb_clock_gen.sv
tests/rx_frontend_assertions.sv
tests/tb_rx_frontend.sv
